// ==== decode_stage.f ====
design/isa_pkg.sv
design/reg_file.sv
design/control_unit.sv
design/jump_detection_unit.sv
design/decode_stage.sv
verification/decode_stage_properties.sv
verification/decode_stage_tb.sv

// ==== design/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  isa_pkg::opcode_e           opcode,
    input  logic [isa_pkg::reg_aw-1:0] dest,
    output isa_pkg::jump_e             jump_type,
    output isa_pkg::ex_ctrl_t          ex_ctrl,
    output isa_pkg::mem_ctrl_t         mem_ctrl,
    output isa_pkg::wb_ctrl_t          wb_ctrl
);

    isa_pkg::ctrl_word_t ctrl_dec;

    // stage registers
    isa_pkg::ex_ctrl_t  ex_q;
    isa_pkg::mem_ctrl_t mem_q1;
    isa_pkg::wb_ctrl_t  wb_q1;
    isa_pkg::mem_ctrl_t mem_q2;
    isa_pkg::wb_ctrl_t  wb_q2;
    isa_pkg::wb_ctrl_t  wb_q3;

    //////////////////////////////
    // opcode decode
    //////////////////////////////

    always_comb begin
        ctrl_dec          = '0;
        jump_type         = isa_pkg::jump_none;
        ctrl_dec.ex.valid = 1'b1;

        case (opcode)
            isa_pkg::nop: begin
                ctrl_dec.ex.valid = 1'b0;
            end
            // register to register ALU ops
            isa_pkg::mov: begin
                ctrl_dec.ex.alu_op          = isa_pkg::alu_pass_b;
                ctrl_dec.ex.dest_alu_select = 1'b1;
                ctrl_dec.wb.wb              = 1'b1;
            end
            isa_pkg::add: begin
                ctrl_dec.ex.alu_op          = isa_pkg::alu_add;
                ctrl_dec.ex.dest_alu_select = 1'b1;
                ctrl_dec.wb.wb              = 1'b1;
            end
            isa_pkg::sub: begin
                ctrl_dec.ex.alu_op          = isa_pkg::alu_sub;
                ctrl_dec.ex.dest_alu_select = 1'b1;
                ctrl_dec.wb.wb              = 1'b1;
            end
            isa_pkg::and_op: begin
                ctrl_dec.ex.alu_op          = isa_pkg::alu_and;
                ctrl_dec.ex.dest_alu_select = 1'b1;
                ctrl_dec.wb.wb              = 1'b1;
            end
            isa_pkg::or_op: begin
                ctrl_dec.ex.alu_op          = isa_pkg::alu_or;
                ctrl_dec.ex.dest_alu_select = 1'b1;
                ctrl_dec.wb.wb              = 1'b1;
            end
            // single operand, works on ra
            isa_pkg::not_op: begin
                ctrl_dec.ex.alu_op          = isa_pkg::alu_not;
                ctrl_dec.ex.dest_alu_select = 1'b1;
                ctrl_dec.wb.wb              = 1'b1;
            end
            isa_pkg::inc: begin
                ctrl_dec.ex.alu_op          = isa_pkg::alu_inc;
                ctrl_dec.ex.dest_alu_select = 1'b1;
                ctrl_dec.wb.wb              = 1'b1;
            end
            isa_pkg::dec: begin
                ctrl_dec.ex.alu_op          = isa_pkg::alu_dec;
                ctrl_dec.ex.dest_alu_select = 1'b1;
                ctrl_dec.wb.wb              = 1'b1;
            end
            // immediate goes through the ALU as operand b
            isa_pkg::ldm: begin
                ctrl_dec.ex.alu_op          = isa_pkg::alu_pass_b;
                ctrl_dec.ex.alu_src_imm     = 1'b1;
                ctrl_dec.ex.dest_alu_select = 1'b1;
                ctrl_dec.wb.wb              = 1'b1;
            end
            isa_pkg::ldd: begin
                ctrl_dec.mem.mem_read = 1'b1;
                ctrl_dec.wb.wb        = 1'b1;
            end
            isa_pkg::std: begin
                ctrl_dec.mem.mem_write = 1'b1;
            end
            isa_pkg::push: begin
                ctrl_dec.mem.push = 1'b1;
            end
            isa_pkg::pop: begin
                ctrl_dec.mem.pop      = 1'b1;
                ctrl_dec.mem.mem_read = 1'b1;
                ctrl_dec.wb.wb        = 1'b1;
            end
            isa_pkg::in_op: begin
                ctrl_dec.mem.in_port = 1'b1;
                ctrl_dec.wb.wb       = 1'b1;
            end
            isa_pkg::out_op: begin
                ctrl_dec.mem.out_port = 1'b1;
            end
            // jumps resolve here, nothing goes down the pipe
            isa_pkg::jz:  jump_type = isa_pkg::jump_zero;
            isa_pkg::jn:  jump_type = isa_pkg::jump_negative;
            isa_pkg::jc:  jump_type = isa_pkg::jump_carry;
            isa_pkg::jmp: jump_type = isa_pkg::jump_always;
            default: begin
                ctrl_dec.ex.valid = 1'b0;
            end
        endcase

        // dest only carried for writing instructions
        ctrl_dec.wb.dest = ctrl_dec.wb.wb ? dest : '0;
    end

    //////////////////////////////
    // ex / mem / wb registers
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_q   <= '0;
            mem_q1 <= '0;
            wb_q1  <= '0;
            mem_q2 <= '0;
            wb_q2  <= '0;
            wb_q3  <= '0;
        end else begin
            ex_q   <= ctrl_dec.ex;
            mem_q1 <= ctrl_dec.mem;
            wb_q1  <= ctrl_dec.wb;
            mem_q2 <= mem_q1;
            wb_q2  <= wb_q1;
            wb_q3  <= wb_q2;
        end
    end

    assign ex_ctrl  = ex_q;
    assign mem_ctrl = mem_q2;
    assign wb_ctrl  = wb_q3;

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  isa_pkg::instr_u            instruction,
    input  isa_pkg::ccr_t              ccr,
    input  logic [isa_pkg::data_w-1:0] write_data,
    output logic [isa_pkg::data_w-1:0] read_data1,
    output logic [isa_pkg::data_w-1:0] read_data2,
    output logic [isa_pkg::data_w-1:0] immediate,
    output logic                       jump_taken,
    output isa_pkg::ex_ctrl_t          ex_ctrl,
    output logic [isa_pkg::data_w-1:0] read_data1_ex,
    output logic [isa_pkg::data_w-1:0] read_data2_ex,
    output isa_pkg::mem_ctrl_t         mem_ctrl,
    output logic [isa_pkg::data_w-1:0] read_data2_mem,
    output isa_pkg::wb_ctrl_t          wb_ctrl
);

    //////////////////////////////
    // instruction fields
    //////////////////////////////

    isa_pkg::opcode_e             opcode;
    logic [isa_pkg::reg_aw-1:0]   ra;
    logic [isa_pkg::reg_aw-1:0]   rb;
    isa_pkg::jump_e               jump_type;

    assign opcode = instruction.r.opcode;
    assign ra     = instruction.r.ra;
    assign rb     = instruction.r.rb;

    // low byte of the i-format, zero extended
    assign immediate = {{(isa_pkg::data_w - isa_pkg::imm_w){1'b0}}, instruction.i.imm};

    //////////////////////////////
    // units
    //////////////////////////////

    // write port is fed from the writeback stage control
    reg_file rf (
        .clk            (clk),
        .rst_n          (rst_n),
        .read_addr1     (ra),
        .read_addr2     (rb),
        .write_en       (wb_ctrl.wb),
        .write_addr     (wb_ctrl.dest),
        .write_data     (write_data),
        .read_data1     (read_data1),
        .read_data2     (read_data2),
        .read_data1_ex  (read_data1_ex),
        .read_data2_ex  (read_data2_ex),
        .read_data2_mem (read_data2_mem)
    );

    // ra doubles as the destination register
    control_unit cu (
        .clk       (clk),
        .rst_n     (rst_n),
        .opcode    (opcode),
        .dest      (ra),
        .jump_type (jump_type),
        .ex_ctrl   (ex_ctrl),
        .mem_ctrl  (mem_ctrl),
        .wb_ctrl   (wb_ctrl)
    );

    // target address is read_data1, resolved by fetch
    jump_detection_unit jdu (
        .jump_type  (jump_type),
        .ccr        (ccr),
        .jump_taken (jump_taken)
    );

endmodule

`default_nettype wire

// ==== design/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    localparam int data_w   = 16;
    localparam int reg_aw   = 3;
    localparam int num_regs = 8;
    localparam int imm_w    = 8;

    //////////////////////////////
    // encodings
    //////////////////////////////

    typedef enum logic [4:0] {
        nop    = 5'd0,
        mov    = 5'd1,
        add    = 5'd2,
        sub    = 5'd3,
        and_op = 5'd4,
        or_op  = 5'd5,
        not_op = 5'd6,
        inc    = 5'd7,
        dec    = 5'd8,
        ldm    = 5'd9,
        ldd    = 5'd10,
        std    = 5'd11,
        push   = 5'd12,
        pop    = 5'd13,
        in_op  = 5'd14,
        out_op = 5'd15,
        jz     = 5'd16,
        jn     = 5'd17,
        jc     = 5'd18,
        jmp    = 5'd19
    } opcode_e;

    typedef enum logic [3:0] {
        alu_pass_a = 4'd0,
        alu_pass_b = 4'd1,
        alu_add    = 4'd2,
        alu_sub    = 4'd3,
        alu_and    = 4'd4,
        alu_or     = 4'd5,
        alu_not    = 4'd6,
        alu_inc    = 4'd7,
        alu_dec    = 4'd8
    } alu_op_e;

    typedef enum logic [2:0] {
        jump_none     = 3'd0,
        jump_zero     = 3'd1,
        jump_negative = 3'd2,
        jump_carry    = 3'd3,
        jump_always   = 3'd4
    } jump_e;

    // condition flags, z in the top bit
    typedef struct packed {
        logic z;
        logic n;
        logic c;
    } ccr_t;

    //////////////////////////////
    // instruction formats
    //////////////////////////////

    typedef struct packed {
        opcode_e             opcode;
        logic [reg_aw-1:0]   ra;
        logic [reg_aw-1:0]   rb;
        logic [4:0]          unused;
    } r_fmt_t;

    typedef struct packed {
        opcode_e             opcode;
        logic [reg_aw-1:0]   ra;
        logic [imm_w-1:0]    imm;
    } i_fmt_t;

    // same word, read either as two registers or as register plus immediate
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    //////////////////////////////
    // control words
    //////////////////////////////

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    dest_alu_select;
        logic    valid;
    } ex_ctrl_t;

    typedef struct packed {
        logic mem_read;
        logic mem_write;
        logic push;
        logic pop;
        logic in_port;
        logic out_port;
    } mem_ctrl_t;

    typedef struct packed {
        logic              wb;
        logic [reg_aw-1:0] dest;
    } wb_ctrl_t;

    typedef struct packed {
        ex_ctrl_t  ex;
        mem_ctrl_t mem;
        wb_ctrl_t  wb;
    } ctrl_word_t;

endpackage

`default_nettype wire

// ==== design/jump_detection_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module jump_detection_unit (
    input  isa_pkg::jump_e jump_type,
    input  isa_pkg::ccr_t  ccr,
    output logic           jump_taken
);

    // flag test per jump type
    always_comb begin
        case (jump_type)
            isa_pkg::jump_zero: begin
                jump_taken = ccr.z;
            end
            isa_pkg::jump_negative: begin
                jump_taken = ccr.n;
            end
            isa_pkg::jump_carry: begin
                jump_taken = ccr.c;
            end
            isa_pkg::jump_always: begin
                jump_taken = 1'b1;
            end
            // none and unused codes
            default: begin
                jump_taken = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [isa_pkg::reg_aw-1:0] read_addr1,
    input  logic [isa_pkg::reg_aw-1:0] read_addr2,
    input  logic                       write_en,
    input  logic [isa_pkg::reg_aw-1:0] write_addr,
    input  logic [isa_pkg::data_w-1:0] write_data,
    output logic [isa_pkg::data_w-1:0] read_data1,
    output logic [isa_pkg::data_w-1:0] read_data2,
    output logic [isa_pkg::data_w-1:0] read_data1_ex,
    output logic [isa_pkg::data_w-1:0] read_data2_ex,
    output logic [isa_pkg::data_w-1:0] read_data2_mem
);

    logic [isa_pkg::data_w-1:0] regs [isa_pkg::num_regs];

    //////////////////////////////
    // register array
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < isa_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_addr] <= write_data;
        end
    end

    // async reads, a same-cycle write shows up next cycle
    assign read_data1 = regs[read_addr1];
    assign read_data2 = regs[read_addr2];

    //////////////////////////////
    // operand pipeline
    //////////////////////////////

    // operands into execute
    always_ff @(posedge clk) begin
        read_data1_ex <= read_data1;
        read_data2_ex <= read_data2;
    end

    // store data follows one stage further
    always_ff @(posedge clk) begin
        read_data2_mem <= read_data2_ex;
    end

endmodule

`default_nettype wire

// ==== verification/decode_stage_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_properties (
    input logic               clk,
    input logic               rst_n,
    input isa_pkg::ex_ctrl_t  ex_ctrl,
    input isa_pkg::mem_ctrl_t mem_ctrl,
    input isa_pkg::wb_ctrl_t  wb_ctrl
);

    logic ctrl_active;

    // any bit that would make a later stage act
    assign ctrl_active = ex_ctrl.valid || (|mem_ctrl) || wb_ctrl.wb;

    // quiet in reset and in the first cycle after release
    reset_quiet: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> !ctrl_active)
        else $error("control bits active during or right after reset");

    // memory port does one thing per cycle
    read_write_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_ctrl.mem_read && mem_ctrl.mem_write))
        else $error("mem_read and mem_write high together");

    push_pop_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_ctrl.push && mem_ctrl.pop))
        else $error("push and pop high together");

endmodule

`default_nettype wire

// ==== verification/decode_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

    logic                       clk;
    logic                       rst_n;
    isa_pkg::instr_u            instruction;
    isa_pkg::ccr_t              ccr;
    logic [isa_pkg::data_w-1:0] write_data;
    logic [isa_pkg::data_w-1:0] read_data1, read_data2, immediate;
    logic [isa_pkg::data_w-1:0] read_data1_ex, read_data2_ex, read_data2_mem;
    logic                       jump_taken;
    isa_pkg::ex_ctrl_t          ex_ctrl;
    isa_pkg::mem_ctrl_t         mem_ctrl;
    isa_pkg::wb_ctrl_t          wb_ctrl;

    // reference model state
    logic [isa_pkg::data_w-1:0] exp_regs [isa_pkg::num_regs];
    logic [isa_pkg::data_w-1:0] exp_rd1_ex, exp_rd2_ex, exp_rd2_mem;
    isa_pkg::ctrl_word_t        cw1, cw2, cw3;
    int                         busy [isa_pkg::num_regs];
    int unsigned                fill_count;
    int unsigned                cycle_count;
    string                      test_name;

    decode_stage uut (.*);

    bind decode_stage decode_stage_properties props (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////
    // reference rules
    ////////////////////////////////

    function automatic isa_pkg::ctrl_word_t reference_ctrl(logic [4:0] op, logic [2:0] ra);
        isa_pkg::ctrl_word_t cw;
        cw = '0;
        // nop and codes past jmp are bubbles
        cw.ex.valid = (op != isa_pkg::nop) && (op <= isa_pkg::jmp);
        case (op)
            isa_pkg::mov, isa_pkg::ldm: cw.ex.alu_op = isa_pkg::alu_pass_b;
            isa_pkg::add:    cw.ex.alu_op = isa_pkg::alu_add;
            isa_pkg::sub:    cw.ex.alu_op = isa_pkg::alu_sub;
            isa_pkg::and_op: cw.ex.alu_op = isa_pkg::alu_and;
            isa_pkg::or_op:  cw.ex.alu_op = isa_pkg::alu_or;
            isa_pkg::not_op: cw.ex.alu_op = isa_pkg::alu_not;
            isa_pkg::inc:    cw.ex.alu_op = isa_pkg::alu_inc;
            isa_pkg::dec:    cw.ex.alu_op = isa_pkg::alu_dec;
            default:         cw.ex.alu_op = isa_pkg::alu_pass_a;
        endcase
        // mov through ldm write back the ALU result
        if (op >= isa_pkg::mov && op <= isa_pkg::ldm) begin
            cw.ex.dest_alu_select = 1'b1;
            cw.wb.wb = 1'b1;
        end
        cw.ex.alu_src_imm = (op == isa_pkg::ldm);
        cw.mem.mem_read   = (op == isa_pkg::ldd) || (op == isa_pkg::pop);
        cw.mem.mem_write  = (op == isa_pkg::std);
        cw.mem.push       = (op == isa_pkg::push);
        cw.mem.pop        = (op == isa_pkg::pop);
        cw.mem.in_port    = (op == isa_pkg::in_op);
        cw.mem.out_port   = (op == isa_pkg::out_op);
        if (cw.mem.mem_read || cw.mem.in_port) cw.wb.wb = 1'b1;
        if (cw.wb.wb) cw.wb.dest = ra;
        return cw;
    endfunction

    function automatic logic jump_outcome(logic [4:0] op, isa_pkg::ccr_t flags);
        case (op)
            isa_pkg::jz:  return flags.z;
            isa_pkg::jn:  return flags.n;
            isa_pkg::jc:  return flags.c;
            isa_pkg::jmp: return 1'b1;
            default:      return 1'b0;
        endcase
    endfunction

    ////////////////////////////////
    // model and checks
    ////////////////////////////////

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cw1 <= '0;
            cw2 <= '0;
            cw3 <= '0;
            for (int i = 0; i < isa_pkg::num_regs; i++) begin
                exp_regs[i] <= '0;
            end
        end else begin
            cw1 <= reference_ctrl(instruction.r.opcode, instruction.r.ra);
            cw2 <= cw1;
            cw3 <= cw2;
            if (cw3.wb.wb) exp_regs[cw3.wb.dest] <= write_data;
        end
    end

    // operand copies, and the run limit of roughly 900 cycles plus margin
    always @(posedge clk) begin
        exp_rd1_ex  <= exp_regs[instruction.r.ra];
        exp_rd2_ex  <= exp_regs[instruction.r.rb];
        exp_rd2_mem <= exp_rd2_ex;
        if (fill_count < 3) fill_count <= fill_count + 1;
        cycle_count <= cycle_count + 1;
        if (cycle_count >= 2000) fail_run("run did not finish within 2000 cycles");
    end

    task automatic fail_run(string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare(string what, logic [15:0] expected, logic [15:0] actual);
        assert (actual === expected)
        else fail_run($sformatf("MISMATCH %s %s expected 0x%0h actual 0x%0h",
                                test_name, what, expected, actual));
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (fill_count >= 1) begin
            compare("read_data1", exp_regs[instruction.r.ra], read_data1);
            compare("read_data2", exp_regs[instruction.r.rb], read_data2);
            compare("immediate", {8'h00, instruction.i.imm}, immediate);
            compare("jump_taken", jump_outcome(instruction.r.opcode, ccr), jump_taken);
            compare("ex_ctrl", cw1.ex, ex_ctrl);
            compare("mem_ctrl", cw2.mem, mem_ctrl);
            compare("wb_ctrl", cw3.wb, wb_ctrl);
            compare("read_data1_ex", exp_rd1_ex, read_data1_ex);
            compare("read_data2_ex", exp_rd2_ex, read_data2_ex);
        end
        if (fill_count >= 2) compare("read_data2_mem", exp_rd2_mem, read_data2_mem);
    end

    ////////////////////////////////
    // stimulus
    ////////////////////////////////

    task automatic drive_instruction(logic [4:0] op, logic [2:0] ra, logic [7:0] low,
                                     logic [2:0] flags);
        isa_pkg::instr_u     word;
        isa_pkg::ctrl_word_t cw;
        word.i.opcode = isa_pkg::opcode_e'(op);
        word.i.ra     = ra;
        word.i.imm    = low;
        cw = reference_ctrl(op, ra);
        @(posedge clk);
        instruction <= word;
        ccr         <= flags;
        write_data  <= 16'($urandom);
        for (int i = 0; i < isa_pkg::num_regs; i++) begin
            if (busy[i] > 0) busy[i]--;
        end
        // three slots until the write lands
        if (cw.wb.wb) busy[ra] = 3;
    endtask

    task automatic random_instruction();
        logic [4:0] op;
        logic [2:0] ra;
        logic [7:0] low;
        op  = 5'($urandom);
        ra  = 3'($urandom);
        low = 8'($urandom);
        while (busy[ra] > 0 || busy[low[7:5]] > 0) begin
            drive_instruction(isa_pkg::nop, 3'd0, 8'd0, 3'($urandom));
        end
        drive_instruction(op, ra, low, 3'($urandom));
    endtask

    initial begin
        logic [4:0] jump_ops [5];
        jump_ops = '{isa_pkg::nop, isa_pkg::jz, isa_pkg::jn, isa_pkg::jc, isa_pkg::jmp};
        void'($urandom(67));
        rst_n       = 1'b1;
        instruction = '0;
        ccr         = '0;
        write_data  = '0;
        #1 rst_n = 1'b0;

        test_name = "reset";
        for (int i = 0; i < 10; i++) begin
            drive_instruction(5'($urandom), 3'(i), {3'(7 - i), 5'd0}, 3'($urandom));
        end
        rst_n <= 1'b1;

        test_name = "writeback";
        for (int r = 0; r < isa_pkg::num_regs; r++) begin
            drive_instruction(isa_pkg::ldm, 3'(r), 8'($urandom), 3'd0);
            repeat (3) drive_instruction(isa_pkg::nop, 3'(r), {3'(r), 5'd0}, 3'd0);
        end
        for (int r = 0; r < isa_pkg::num_regs; r++) begin
            drive_instruction(isa_pkg::nop, 3'(r), {3'(7 - r), 5'd0}, 3'd0);
        end

        test_name = "control";
        for (int op = 0; op < 32; op++) begin
            drive_instruction(5'(op), 3'($urandom), 8'($urandom), 3'($urandom));
        end

        test_name = "store";
        for (int r = 0; r < isa_pkg::num_regs; r++) begin
            drive_instruction(isa_pkg::std, 3'(7 - r), {3'(r), 5'($urandom)}, 3'd0);
        end

        test_name = "jump";
        for (int j = 0; j < 5; j++) begin
            for (int f = 0; f < 8; f++) begin
                drive_instruction(jump_ops[j], 3'($urandom), 8'($urandom), 3'(f));
            end
        end

        test_name = "random";
        repeat (400) random_instruction();
        // let the last writes drain
        repeat (4) drive_instruction(isa_pkg::nop, 3'd0, 8'd0, 3'd0);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
